/* vlog.f */
cdc_sync_pkg.sv
cdc_clear_pkg.sv
cdc_sync.sv
cdc_2phase_src.sv
cdc_2phase_dst.sv
cdc_reset_ctrlr_half.sv
cdc_reset_ctrlr.sv
cdc_2phase_clearable.sv
cdc_2phase_clearable_checker.sv
tb_cdc_2phase_clearable.sv

/* tb_cdc_2phase_clearable.sv */
// Clearable CDC testbench
`timescale 1ns/100ps

module tb_cdc_2phase_clearable;

  localparam int unsigned DATA_WIDTH    = 32;
  localparam int unsigned DST_PERIOD_NS = 11;
  localparam int unsigned SEED          = 86213;
  // test lengths in words where the reset test counts as a short one
  localparam int unsigned RESET_LEN     = 20;
  localparam int unsigned TRAFFIC_WORDS = 200;
  localparam int unsigned CLEAR_WORDS   = 60;
  localparam int unsigned TOTAL_LEN     = RESET_LEN + TRAFFIC_WORDS + 3 * CLEAR_WORDS;
  localparam int unsigned NO_CLEAR      = 32'hffff_ffff;

  logic                  src_clk = 1'b0;
  logic                  dst_clk = 1'b0;
  logic                  src_rst_n;
  logic                  dst_rst_n;
  logic                  src_clear;
  logic                  src_valid;
  logic [DATA_WIDTH-1:0] src_data;
  logic                  src_ready;
  logic                  src_clear_pending;
  logic                  dst_clear;
  logic                  dst_ready;
  logic                  dst_valid;
  logic [DATA_WIDTH-1:0] dst_data;
  logic                  dst_clear_pending;

  int unsigned           next_seq = 1;
  int unsigned           rcvd_count = 0;
  logic [DATA_WIDTH-1:0] last_rcvd = '0;
  int unsigned           tb_fails = 0;
  int unsigned           fails_before = 0;
  int unsigned           tests_ok = 0;
  int unsigned           tests_failed = 0;
  int unsigned           rcvd_start;

  always #4 src_clk = ~src_clk;
  always #(DST_PERIOD_NS / 2.0) dst_clk = ~dst_clk;

  cdc_2phase_clearable #(
    .DATA_WIDTH           ( DATA_WIDTH ),
    .SYNC_STAGES          ( 3          ),
    .CLEAR_ON_ASYNC_RESET ( 1'b1       )
  ) i_cdc_2phase_clearable (
    .src_rst_ni          ( src_rst_n         ),
    .src_clk_i           ( src_clk           ),
    .src_clear_i         ( src_clear         ),
    .src_clear_pending_o ( src_clear_pending ),
    .src_data_i          ( src_data          ),
    .src_valid_i         ( src_valid         ),
    .src_ready_o         ( src_ready         ),
    .dst_rst_ni          ( dst_rst_n         ),
    .dst_clk_i           ( dst_clk           ),
    .dst_clear_i         ( dst_clear         ),
    .dst_clear_pending_o ( dst_clear_pending ),
    .dst_data_o          ( dst_data          ),
    .dst_valid_o         ( dst_valid         ),
    .dst_ready_i         ( dst_ready         )
  );

  // destination back-pressure keeps ready high in about seven of ten cycles
  always begin
    @(posedge dst_clk);
    #1;
    dst_ready = ($urandom_range(9, 0) < 7);
  end

  // inputs and outputs are settled at the falling edge, so a word seen here
  // is taken by the next rising edge
  always @(negedge dst_clk) begin
    if (dst_rst_n && dst_valid && dst_ready) begin
      rcvd_count++;
      last_rcvd = dst_data;
    end
  end

  task automatic src_cycle();
    @(posedge src_clk);
    #1;
  endtask

  task automatic dst_cycle();
    @(posedge dst_clk);
    #1;
  endtask

  function automatic int unsigned error_total();
    return tb_fails + i_cdc_2phase_clearable.i_checker.fail_count;
  endfunction

  task automatic apply_reset();
    #1;
    src_rst_n = 1'b0;
    dst_rst_n = 1'b0;
    fork
      begin
        repeat (2) @(posedge src_clk);
        #1 src_rst_n = 1'b1;
      end
      begin
        repeat (2) @(posedge dst_clk);
        #1 dst_rst_n = 1'b1;
      end
    join
  endtask

  // words carry incrementing sequence numbers
  // a clear pulse goes out in the idle cycle before word clear_at so it
  // never meets a rising valid
  task automatic send_words(input int unsigned count, input int unsigned clear_at);
    int unsigned gap;
    for (int unsigned i = 0; i < count; i++) begin
      gap = $urandom_range(3, 0);
      repeat (gap) src_cycle();
      if (i == clear_at) begin
        src_clear = 1'b1;
        src_cycle();
        src_clear = 1'b0;
      end
      src_valid = 1'b1;
      src_data  = next_seq;
      while (!src_ready) begin
        src_cycle();
      end
      src_cycle();
      src_valid = 1'b0;
      next_seq++;
    end
  endtask

  // waits for the source side to enter a clear, then for both sides to leave it
  // the destination side has to take part in the same sequence
  task automatic watch_clear(input string name, input int unsigned max_cycles);
    int unsigned cycles;
    logic        dst_seen;
    cycles   = 0;
    dst_seen = 1'b0;
    while (!src_clear_pending && cycles < max_cycles) begin
      if (dst_clear_pending) begin
        dst_seen = 1'b1;
      end
      src_cycle();
      cycles++;
    end
    if (!src_clear_pending) begin
      tb_fails++;
      $display("%s: source clear pending did not rise within %0d cycles", name, max_cycles);
    end
    while (src_clear_pending || dst_clear_pending) begin
      if (dst_clear_pending) begin
        dst_seen = 1'b1;
      end
      src_cycle();
    end
    if (!dst_seen) begin
      tb_fails++;
      $display("%s: destination clear pending never rose during the clear", name);
    end
  endtask

  task automatic wait_delivery();
    wait (last_rcvd == next_seq - 1);
    repeat (4) dst_cycle();
  endtask

  task automatic finish_test(input string name);
    int unsigned fails;
    fails = error_total() - fails_before;
    if (fails == 0) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, fails);
    end
    fails_before = error_total();
  endtask

  initial begin : watchdog
    #(TOTAL_LEN * 20 * DST_PERIOD_NS);
    $display("timeout after %0d ns, the tests did not finish", TOTAL_LEN * 20 * DST_PERIOD_NS);
    $display("Test failures found");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    src_rst_n = 1'b1;
    dst_rst_n = 1'b1;
    src_clear = 1'b0;
    src_valid = 1'b0;
    src_data  = '0;
    dst_clear = 1'b0;
    dst_ready = 1'b0;

    // reset values are checked on the first edges, then the boot clear runs
    apply_reset();
    watch_clear("reset", 50);
    finish_test("reset");

    rcvd_start = rcvd_count;
    send_words(TRAFFIC_WORDS, NO_CLEAR);
    wait_delivery();
    assert (rcvd_count - rcvd_start == TRAFFIC_WORDS) else begin
      tb_fails++;
      $display("Fail random_traffic: expected %0d, actual %0d",
               TRAFFIC_WORDS, rcvd_count - rcvd_start);
    end
    finish_test("random_traffic");

    fork
      send_words(CLEAR_WORDS, CLEAR_WORDS / 3);
      watch_clear("src_clear", 4000);
    join
    wait_delivery();
    finish_test("src_clear");

    fork
      send_words(CLEAR_WORDS, NO_CLEAR);
      begin
        repeat (30) dst_cycle();
        dst_clear = 1'b1;
        dst_cycle();
        dst_clear = 1'b0;
        watch_clear("dst_clear", 200);
      end
    join
    wait_delivery();
    finish_test("dst_clear");

    // only the destination is reset and its boot clear has to reach the source
    fork
      send_words(CLEAR_WORDS, NO_CLEAR);
      begin
        repeat (30) dst_cycle();
        dst_rst_n = 1'b0;
        repeat (2) dst_cycle();
        dst_rst_n = 1'b1;
        watch_clear("dst_async_reset", 200);
      end
    join
    wait_delivery();
    finish_test("dst_async_reset");

    $display("%0d tests ok, %0d tests failed", tests_ok, tests_failed);
    if (tests_failed == 0 && error_total() == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* cdc_2phase_clearable_checker.sv */
// Clearable CDC assertions
`timescale 1ns/100ps

module cdc_2phase_clearable_checker #(
  parameter int unsigned DATA_WIDTH = 32
) (
  input logic                  src_clk_i,
  input logic                  src_rst_ni,
  input logic                  src_clear_i,
  input logic                  src_clear_pending_o,
  input logic [DATA_WIDTH-1:0] src_data_i,
  input logic                  src_valid_i,
  input logic                  src_ready_o,
  input logic                  dst_clk_i,
  input logic                  dst_rst_ni,
  input logic                  dst_clear_i,
  input logic                  dst_clear_pending_o,
  input logic [DATA_WIDTH-1:0] dst_data_o,
  input logic                  dst_valid_o,
  input logic                  dst_ready_i
);

  // number of failed checks since the start of the run
  int unsigned fail_count = 0;

  // sequence numbers seen on each side, kept across a reset of either side
  logic [DATA_WIDTH-1:0] last_sent  = '0;
  logic [DATA_WIDTH-1:0] last_rcvd  = '0;
  logic                  got_any    = 1'b0;
  logic                  clear_seen = 1'b0;

  always_ff @(posedge src_clk_i) begin
    if (src_rst_ni && src_valid_i && src_ready_o) begin
      last_sent <= src_data_i;
    end
  end

  // a clear or a reset of the destination may drop the word in flight,
  // so the next word only has to be larger than the last one
  always_ff @(posedge dst_clk_i) begin
    if (dst_rst_ni && dst_valid_o && dst_ready_i) begin
      last_rcvd  <= dst_data_o;
      got_any    <= 1'b1;
      clear_seen <= 1'b0;
    end else if (!dst_rst_ni || dst_clear_pending_o) begin
      clear_seen <= 1'b1;
    end
  end

  // in reset and on the first edge after it the controls are inactive
  a_src_reset_values: assert property (@(posedge src_clk_i)
    !src_rst_ni || $rose(src_rst_ni) |-> src_ready_o && !src_clear_pending_o)
    else begin
      fail_count++;
      $error("source ready was low or clear pending high around reset");
    end

  a_dst_reset_values: assert property (@(posedge dst_clk_i)
    !dst_rst_ni || $rose(dst_rst_ni) |-> !dst_valid_o && !dst_clear_pending_o)
    else begin
      fail_count++;
      $error("destination valid or clear pending was high around reset");
    end

  // isolation masks the handshake on both sides for the whole sequence
  a_src_isolated: assert property (@(posedge src_clk_i) disable iff (!src_rst_ni)
    src_clear_pending_o |-> !src_ready_o)
    else begin
      fail_count++;
      $error("source ready was high while its clear was pending");
    end

  a_dst_isolated: assert property (@(posedge dst_clk_i) disable iff (!dst_rst_ni)
    dst_clear_pending_o |-> !dst_valid_o)
    else begin
      fail_count++;
      $error("destination valid was high while its clear was pending");
    end

  // a local clear pulse shows up as pending in the very next cycle
  a_src_clear_starts: assert property (@(posedge src_clk_i) disable iff (!src_rst_ni)
    src_clear_i |=> src_clear_pending_o)
    else begin
      fail_count++;
      $error("source clear pending did not rise after a source clear");
    end

  a_dst_clear_starts: assert property (@(posedge dst_clk_i) disable iff (!dst_rst_ni)
    dst_clear_i |=> dst_clear_pending_o)
    else begin
      fail_count++;
      $error("destination clear pending did not rise after a destination clear");
    end

  // without a clear in between no word may go missing
  a_in_order: assert property (@(posedge dst_clk_i) disable iff (!dst_rst_ni)
    dst_valid_o && dst_ready_i && got_any && !clear_seen |-> dst_data_o == last_rcvd + 1)
    else begin
      fail_count++;
      $error("Fail in_order: expected %0d, actual %0d",
             $sampled(last_rcvd) + 1, $sampled(dst_data_o));
    end

  // a repeated word is not larger than the last one, a spurious one was never sent
  a_no_dup_spurious: assert property (@(posedge dst_clk_i) disable iff (!dst_rst_ni)
    dst_valid_o && dst_ready_i |-> dst_data_o > last_rcvd && dst_data_o <= last_sent)
    else begin
      fail_count++;
      $error("Fail no_dup_spurious: expected %0d to %0d, actual %0d",
             $sampled(last_rcvd) + 1, $sampled(last_sent), $sampled(dst_data_o));
    end

endmodule

bind cdc_2phase_clearable cdc_2phase_clearable_checker #(
  .DATA_WIDTH ( DATA_WIDTH )
) i_checker (.*);

/* cdc_2phase_clearable.sv */
// Clearable two-phase CDC
`timescale 1ns/100ps

module cdc_2phase_clearable #(
  parameter int unsigned DATA_WIDTH           = 32,
  parameter int unsigned SYNC_STAGES          = cdc_sync_pkg::SyncStagesDefault,
  parameter bit          CLEAR_ON_ASYNC_RESET = cdc_clear_pkg::ClearOnAsyncResetDefault
) (
  input  logic                  src_rst_ni,
  input  logic                  src_clk_i,
  input  logic                  src_clear_i,
  output logic                  src_clear_pending_o,
  input  logic [DATA_WIDTH-1:0] src_data_i,
  input  logic                  src_valid_i,
  output logic                  src_ready_o,
  input  logic                  dst_rst_ni,
  input  logic                  dst_clk_i,
  input  logic                  dst_clear_i,
  output logic                  dst_clear_pending_o,
  output logic [DATA_WIDTH-1:0] dst_data_o,
  output logic                  dst_valid_o,
  input  logic                  dst_ready_i
);

  import cdc_sync_pkg::*;

  logic                  src_clear;
  logic                  src_clear_ack_q;
  logic                  src_isolate;
  logic                  src_isolate_ack_q;
  logic                  src_ready;
  logic                  dst_clear;
  logic                  dst_clear_ack_q;
  logic                  dst_isolate;
  logic                  dst_isolate_ack_q;
  logic                  dst_valid;
  // these nets cross the clock boundary
  logic                  async_req;
  logic                  async_ack;
  logic [DATA_WIDTH-1:0] async_data;

  // an async reset has to be isolated before the peer's toggle reaches the
  // handshake logic, so that option needs one synchronizer stage more
  if (CLEAR_ON_ASYNC_RESET) begin : gen_check_async
    if (SYNC_STAGES < MinSyncStagesAsyncClear) begin : gen_too_few
      $error("clear on async reset needs at least %0d synchronizer stages",
             MinSyncStagesAsyncClear);
    end
  end else begin : gen_check_sync
    if (SYNC_STAGES < MinSyncStages) begin : gen_too_few
      $error("at least %0d synchronizer stages are needed", MinSyncStages);
    end
  end

  // valid is masked during isolation so that no word is taken mid-sequence
  cdc_2phase_src #(
    .DATA_WIDTH  ( DATA_WIDTH  ),
    .SYNC_STAGES ( SYNC_STAGES )
  ) i_src (
    .clk_i        ( src_clk_i                   ),
    .rst_ni       ( src_rst_ni                  ),
    .clear_i      ( src_clear                   ),
    .data_i       ( src_data_i                  ),
    .valid_i      ( src_valid_i && !src_isolate ),
    .ready_o      ( src_ready                   ),
    .async_req_o  ( async_req                   ),
    .async_ack_i  ( async_ack                   ),
    .async_data_o ( async_data                  )
  );

  assign src_ready_o = src_ready && !src_isolate;

  cdc_2phase_dst #(
    .DATA_WIDTH  ( DATA_WIDTH  ),
    .SYNC_STAGES ( SYNC_STAGES )
  ) i_dst (
    .clk_i        ( dst_clk_i                   ),
    .rst_ni       ( dst_rst_ni                  ),
    .clear_i      ( dst_clear                   ),
    .data_o       ( dst_data_o                  ),
    .valid_o      ( dst_valid                   ),
    .ready_i      ( dst_ready_i && !dst_isolate ),
    .async_req_i  ( async_req                   ),
    .async_ack_o  ( async_ack                   ),
    .async_data_i ( async_data                  )
  );

  assign dst_valid_o = dst_valid && !dst_isolate;

  // the phase channel runs one stage shorter than the data path
  // because each phase message is registered once more on both ends
  cdc_reset_ctrlr #(
    .SYNC_STAGES          ( SYNC_STAGES - 1      ),
    .CLEAR_ON_ASYNC_RESET ( CLEAR_ON_ASYNC_RESET )
  ) i_cdc_reset_ctrlr (
    .a_clk_i         ( src_clk_i         ),
    .a_rst_ni        ( src_rst_ni        ),
    .a_clear_i       ( src_clear_i       ),
    .a_clear_o       ( src_clear         ),
    .a_clear_ack_i   ( src_clear_ack_q   ),
    .a_isolate_o     ( src_isolate       ),
    .a_isolate_ack_i ( src_isolate_ack_q ),
    .b_clk_i         ( dst_clk_i         ),
    .b_rst_ni        ( dst_rst_ni        ),
    .b_clear_i       ( dst_clear_i       ),
    .b_clear_o       ( dst_clear         ),
    .b_clear_ack_i   ( dst_clear_ack_q   ),
    .b_isolate_o     ( dst_isolate       ),
    .b_isolate_ack_i ( dst_isolate_ack_q )
  );

  // masking takes effect in the same cycle, so one register is enough
  // to confirm isolate and clear back to the sequencer
  always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      src_isolate_ack_q <= 1'b0;
      src_clear_ack_q   <= 1'b0;
    end else begin
      src_isolate_ack_q <= src_isolate;
      src_clear_ack_q   <= src_clear;
    end
  end

  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      dst_isolate_ack_q <= 1'b0;
      dst_clear_ack_q   <= 1'b0;
    end else begin
      dst_isolate_ack_q <= dst_isolate;
      dst_clear_ack_q   <= dst_clear;
    end
  end

  // isolation spans the whole sequence on each side
  assign src_clear_pending_o = src_isolate;
  assign dst_clear_pending_o = dst_isolate;

endmodule

/* cdc_reset_ctrlr.sv */
// Two-sided clear controller
`timescale 1ns/100ps

module cdc_reset_ctrlr #(
  parameter int unsigned SYNC_STAGES          = cdc_sync_pkg::SyncStagesDefault - 1,
  parameter bit          CLEAR_ON_ASYNC_RESET = cdc_clear_pkg::ClearOnAsyncResetDefault
) (
  input  logic a_clk_i,
  input  logic a_rst_ni,
  input  logic a_clear_i,
  output logic a_clear_o,
  input  logic a_clear_ack_i,
  output logic a_isolate_o,
  input  logic a_isolate_ack_i,
  input  logic b_clk_i,
  input  logic b_rst_ni,
  input  logic b_clear_i,
  output logic b_clear_o,
  input  logic b_clear_ack_i,
  output logic b_isolate_o,
  input  logic b_isolate_ack_i
);

  import cdc_clear_pkg::*;

  // each half initiates on its own channel and follows on the peer's one
  cdc_clear_phase_e a_phase;
  cdc_clear_phase_e b_phase;
  logic             a_phase_req;
  logic             b_phase_req;
  logic             a_phase_ack;
  logic             b_phase_ack;

  cdc_reset_ctrlr_half #(
    .SYNC_STAGES          ( SYNC_STAGES          ),
    .CLEAR_ON_ASYNC_RESET ( CLEAR_ON_ASYNC_RESET )
  ) i_half_a (
    .clk_i         ( a_clk_i         ),
    .rst_ni        ( a_rst_ni        ),
    .clear_i       ( a_clear_i       ),
    .clear_o       ( a_clear_o       ),
    .clear_ack_i   ( a_clear_ack_i   ),
    .isolate_o     ( a_isolate_o     ),
    .isolate_ack_i ( a_isolate_ack_i ),
    .phase_o       ( a_phase         ),
    .phase_req_o   ( a_phase_req     ),
    .phase_ack_i   ( b_phase_ack     ),
    .phase_i       ( b_phase         ),
    .phase_req_i   ( b_phase_req     ),
    .phase_ack_o   ( a_phase_ack     )
  );

  cdc_reset_ctrlr_half #(
    .SYNC_STAGES          ( SYNC_STAGES          ),
    .CLEAR_ON_ASYNC_RESET ( CLEAR_ON_ASYNC_RESET )
  ) i_half_b (
    .clk_i         ( b_clk_i         ),
    .rst_ni        ( b_rst_ni        ),
    .clear_i       ( b_clear_i       ),
    .clear_o       ( b_clear_o       ),
    .clear_ack_i   ( b_clear_ack_i   ),
    .isolate_o     ( b_isolate_o     ),
    .isolate_ack_i ( b_isolate_ack_i ),
    .phase_o       ( b_phase         ),
    .phase_req_o   ( b_phase_req     ),
    .phase_ack_i   ( a_phase_ack     ),
    .phase_i       ( a_phase         ),
    .phase_req_i   ( a_phase_req     ),
    .phase_ack_o   ( b_phase_ack     )
  );

endmodule

/* cdc_reset_ctrlr_half.sv */
// Clear sequencer half
`timescale 1ns/100ps

module cdc_reset_ctrlr_half #(
  parameter int unsigned SYNC_STAGES          = cdc_sync_pkg::SyncStagesDefault - 1,
  parameter bit          CLEAR_ON_ASYNC_RESET = cdc_clear_pkg::ClearOnAsyncResetDefault
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  output logic                            clear_o,
  input  logic                            clear_ack_i,
  output logic                            isolate_o,
  input  logic                            isolate_ack_i,
  output cdc_clear_pkg::cdc_clear_phase_e phase_o,
  output logic                            phase_req_o,
  input  logic                            phase_ack_i,
  input  cdc_clear_pkg::cdc_clear_phase_e phase_i,
  input  logic                            phase_req_i,
  output logic                            phase_ack_o
);

  import cdc_clear_pkg::*;

  // initiator side, which runs a sequence of its own
  cdc_clear_phase_e phase_q, phase_d;
  logic             busy_q, busy_d;
  logic             pend_q, pend_d;
  logic             req_q, req_d;
  logic             boot_q;
  logic             ack_synced;
  logic             start;
  logic             local_done;
  // follower side, which applies the phases that the peer sends
  cdc_clear_phase_e follow_phase_q;
  logic             follow_pend_q;
  logic             follow_ack_q;
  logic             req_synced;

  cdc_sync #(
    .STAGES ( SYNC_STAGES )
  ) i_sync_ack (
    .clk_i    ( clk_i       ),
    .rst_ni   ( rst_ni      ),
    .serial_i ( phase_ack_i ),
    .serial_o ( ack_synced  )
  );

  cdc_sync #(
    .STAGES ( SYNC_STAGES )
  ) i_sync_req (
    .clk_i    ( clk_i       ),
    .rst_ni   ( rst_ni      ),
    .serial_i ( phase_req_i ),
    .serial_o ( req_synced  )
  );

  // with async clear on, the first cycle after reset acts as a clear request
  assign start = clear_i || boot_q;

  // both outputs are merged from both sides, so a simultaneous clear on
  // the two halves keeps the stricter of the two phases
  // the initiator stays isolated until the peer has acknowledged its idle phase
  assign isolate_o = busy_q || (follow_phase_q != PhaseIdle);
  assign clear_o   = (phase_q == PhaseClear) || (follow_phase_q == PhaseClear);

  // the top level echoes each request one registered cycle later
  assign local_done = (isolate_ack_i == isolate_o) && (clear_ack_i == clear_o);

  // a new phase word is set one cycle before its request toggles, and the
  // next step waits until both the peer and the local logic have applied it
  always_comb begin
    phase_d = phase_q;
    busy_d  = busy_q;
    pend_d  = pend_q;
    req_d   = req_q;
    if (!busy_q) begin
      if (start) begin
        busy_d  = 1'b1;
        phase_d = PhaseIsolate;
        pend_d  = 1'b1;
      end
    end else if (pend_q) begin
      req_d  = ~req_q;
      pend_d = 1'b0;
    end else if ((ack_synced == req_q) && local_done) begin
      pend_d = 1'b1;
      unique case (phase_q)
        PhaseIsolate:   phase_d = PhaseClear;
        PhaseClear:     phase_d = PhasePostClear;
        PhasePostClear: phase_d = PhaseIdle;
        default: begin
          // the peer has released as well and the toggle is back at zero
          busy_d = 1'b0;
          pend_d = 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= PhaseIdle;
      busy_q  <= 1'b0;
      pend_q  <= 1'b0;
      req_q   <= 1'b0;
      boot_q  <= CLEAR_ON_ASYNC_RESET;
    end else begin
      phase_q <= phase_d;
      busy_q  <= busy_d;
      pend_q  <= pend_d;
      req_q   <= req_d;
      boot_q  <= 1'b0;
    end
  end

  // the peer's phase word has been stable since before its request toggled
  // and is only acknowledged once this side's isolate and clear have settled
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      follow_phase_q <= PhaseIdle;
      follow_pend_q  <= 1'b0;
      follow_ack_q   <= 1'b0;
    end else if (!follow_pend_q && (req_synced != follow_ack_q)) begin
      follow_phase_q <= phase_i;
      follow_pend_q  <= 1'b1;
    end else if (follow_pend_q && local_done) begin
      follow_ack_q  <= ~follow_ack_q;
      follow_pend_q <= 1'b0;
    end
  end

  assign phase_o     = phase_q;
  assign phase_req_o = req_q;
  assign phase_ack_o = follow_ack_q;

endmodule

/* cdc_2phase_dst.sv */
// Two-phase CDC destination half
`timescale 1ns/100ps

module cdc_2phase_dst #(
  parameter int unsigned DATA_WIDTH  = 32,
  parameter int unsigned SYNC_STAGES = cdc_sync_pkg::SyncStagesDefault
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  output logic [DATA_WIDTH-1:0] data_o,
  output logic                  valid_o,
  input  logic                  ready_i,
  input  logic                  async_req_i,
  output logic                  async_ack_o,
  input  logic [DATA_WIDTH-1:0] async_data_i
);

  logic                  ack_q;
  logic                  req_synced;
  logic                  req_synced_q1;
  logic                  req_edge;
  logic [DATA_WIDTH-1:0] data_q;

  // the request toggle comes from the source clock domain
  cdc_sync #(
    .STAGES ( SYNC_STAGES )
  ) i_sync_req (
    .clk_i    ( clk_i       ),
    .rst_ni   ( rst_ni      ),
    .serial_i ( async_req_i ),
    .serial_o ( req_synced  )
  );

  // delayed copy of the synchronized request marks the cycle of a new toggle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_synced_q1 <= 1'b0;
    end else begin
      req_synced_q1 <= req_synced;
    end
  end

  assign req_edge = (req_synced != req_synced_q1);

  // a word is pending while the acknowledge lags the delayed request
  assign valid_o = (ack_q != req_synced_q1);

  // the source data bus has been stable since before its request toggled,
  // so it can be sampled in the edge detection cycle
  always_ff @(posedge clk_i) begin
    if (req_edge && !valid_o) begin
      data_q <= async_data_i;
    end
  end

  // every accepted word flips the acknowledge, a clear forces it to zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else if (clear_i) begin
      ack_q <= 1'b0;
    end else if (valid_o && ready_i) begin
      ack_q <= ~ack_q;
    end
  end

  assign data_o      = data_q;
  assign async_ack_o = ack_q;

endmodule

/* cdc_2phase_src.sv */
// Two-phase CDC source half
`timescale 1ns/100ps

module cdc_2phase_src #(
  parameter int unsigned DATA_WIDTH  = 32,
  parameter int unsigned SYNC_STAGES = cdc_sync_pkg::SyncStagesDefault
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic [DATA_WIDTH-1:0] data_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  output logic                  async_req_o,
  input  logic                  async_ack_i,
  output logic [DATA_WIDTH-1:0] async_data_o
);

  logic                  req_q;
  logic                  ack_synced;
  logic                  accept;
  logic [DATA_WIDTH-1:0] data_q;

  // the acknowledge toggle comes from the destination clock domain
  cdc_sync #(
    .STAGES ( SYNC_STAGES )
  ) i_sync_ack (
    .clk_i    ( clk_i       ),
    .rst_ni   ( rst_ni      ),
    .serial_i ( async_ack_i ),
    .serial_o ( ack_synced  )
  );

  // the destination has taken the last word once its acknowledge has caught up
  assign ready_o = (req_q == ack_synced);
  assign accept  = valid_i && ready_o;

  // every accepted word flips the request, a clear brings it back to zero
  // so that both toggles restart from the same value after the sequence
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
    end else if (clear_i) begin
      req_q <= 1'b0;
    end else if (accept) begin
      req_q <= ~req_q;
    end
  end

  // the word must be stable before the request toggles, so it is loaded in
  // the same edge and held until the next acceptance
  always_ff @(posedge clk_i) begin
    if (accept && !clear_i) begin
      data_q <= data_i;
    end
  end

  assign async_req_o  = req_q;
  assign async_data_o = data_q;

endmodule

/* cdc_sync.sv */
// Flip-flop bit synchronizer
`timescale 1ns/100ps

module cdc_sync #(
  parameter int unsigned STAGES = cdc_sync_pkg::SyncStagesDefault
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic serial_i,
  output logic serial_o
);

  // the whole chain is tagged so that placement keeps the stages close together
  (* async_reg = "true" *)
  logic [STAGES-1:0] sync_q;

  // first stage samples the foreign signal, every later stage lets a
  // metastable value settle for one more clock period
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q <= '0;
    end else begin
      sync_q[0] <= serial_i;
      for (int i = 1; i < STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // the last stage is the only one that is safe to use in this domain
  assign serial_o = sync_q[STAGES-1];

endmodule

/* cdc_clear_pkg.sv */
// Clear sequence definitions

package cdc_clear_pkg;

  // phase word that the two sequencer halves exchange across the boundary
  // each complete sequence sends all four values, so the phase request and
  // acknowledge toggles are back at zero once a sequence has ended
  typedef enum logic [1:0] {
    // no clear in progress, isolation released
    PhaseIdle      = 2'd0,
    // valid and ready are masked on both sides
    PhaseIsolate   = 2'd1,
    // toggle registers are forced to zero while isolated
    PhaseClear     = 2'd2,
    // clear is released but the isolation still holds
    PhasePostClear = 2'd3
  } cdc_clear_phase_e;

  // an async reset of either side also starts a clear sequence
  localparam bit ClearOnAsyncResetDefault = 1'b1;

endpackage

/* cdc_sync_pkg.sv */
// Synchronizer stage constants

package cdc_sync_pkg;

  // default depth of every flip-flop synchronizer in the crossing
  localparam int unsigned SyncStagesDefault = 3;

  // two stages are enough when only synchronous clears are used
  localparam int unsigned MinSyncStages = 2;

  // an async reset of one side must be isolated before the peer's
  // synchronizer output can reach the handshake logic, which needs one stage more
  localparam int unsigned MinSyncStagesAsyncClear = 3;

endpackage
